/* common/panelPkg.sv */
package panelPkg;

	localparam int SLOT_DIVISOR = 4; // Clk cycles per panel slot.
	localparam int SLOT_COUNT_WIDTH = $clog2(SLOT_DIVISOR);
	localparam int DIGIT_COUNT = 10; // nixie digits, also keyboard columns.

	// view select keys sit in column 0 of the keyboard.
	localparam int KEY_IRAM = 0;
	localparam int KEY_DRAM = 1;

	typedef struct packed {
		logic [17:0] ipCounter;
		logic [8:0] loopCounter;
		logic [14:0] apCounter;
		logic [8:0] dataCounter;
	} dekatronState;

	// slot order on the shared panel bus.
	typedef enum logic [2:0] {
		slotClear,
		slotCathode,
		slotAnode,
		slotKbWrite,
		slotKbRead,
		slotMsAddr,
		slotMsData,
		slotIdle
	} panelSlot;

	// two cathode digits packed into one bus byte.
	typedef struct packed {
		logic zeroHigh;
		logic [2:0] apData;
		logic zeroLow;
		logic [2:0] ipLoop;
	} cathodePair;

	typedef union packed {
		logic [7:0] raw;
		cathodePair pair;
	} panelWord;

	typedef struct packed {
		logic in12Clear;
		logic in12Cathode;
		logic in12Anode;
		logic kbWrite;
		logic kbRead;
		logic msAddr;
		logic msData;
	} panelStrobes;

	// column c, row r lives at bit 4c+r.
	typedef logic [39:0] keyState;

endpackage

/* display/ms6205Writer.sv */
`timescale 1ns/1ps

module ms6205Writer
	import panelPkg::*;
(
	input logic Clk,
	input logic reset,
	input logic dataGrant,
	input dekatronState counters,
	input keyState keys,
	output panelWord addrWord,
	output panelWord dataWord
);

	logic [3:0] address;
	logic [31:0] view;

	// the address only moves once a data write has really gone out.
	always_ff @(posedge Clk) begin
		if (reset)
			address <= 4'd0;
		else if (dataGrant)
			address <= address + 4'd1;
	end

	always_comb begin
		if (keys[KEY_IRAM])
			view = 32'(counters.ipCounter);
		else if (keys[KEY_DRAM])
			view = 32'(counters.dataCounter);
		else
			view = 32'(counters.apCounter); // default view is the AP counter.
	end

	assign addrWord.raw = {4'b0000, address};
	assign dataWord.raw = view[8 * address[1:0] +: 8]; // the view repeats every four cells.

endmodule

/* display/nixieScanner.sv */
`timescale 1ns/1ps

module nixieScanner
	import panelPkg::*;
(
	input logic Clk,
	input logic reset,
	input logic frameEnd,
	input dekatronState counters,
	output logic [3:0] digit,
	output panelWord anodeWord,
	output panelWord cathodeWord
);

	logic [26:0] ipLoopBits;
	logic [27:0] apDataBits;
	cathodePair pair;

	assign ipLoopBits = {counters.ipCounter, counters.loopCounter};
	assign apDataBits = {counters.apCounter, 4'b0000, counters.dataCounter};

	// one anode per frame, wrapping after the last digit.
	always_ff @(posedge Clk) begin
		if (reset)
			digit <= 4'd0;
		else if (frameEnd) begin
			if (digit == 4'(DIGIT_COUNT - 1))
				digit <= 4'd0;
			else
				digit <= digit + 4'd1;
		end
	end

	always_comb begin
		pair = '0;
		if (digit < 4'(DIGIT_COUNT - 1)) begin
			pair.ipLoop = ipLoopBits[3 * digit +: 3];
			pair.apData = apDataBits[3 * digit +: 3];
		end
	end

	assign cathodeWord.pair = pair;

	// only eight anodes fit on the bus byte.
	always_comb begin
		anodeWord.raw = 8'h00;
		if (digit < 4'd8)
			anodeWord.raw = 8'h01 << digit;
	end

endmodule

/* frontPanel.f */
common/panelPkg.sv
verilog/slotTicker.sv
display/nixieScanner.sv
display/ms6205Writer.sv
keyboard/keyboardScanner.sv
verilog/panelSequencer.sv
verilog/frontPanel.sv
sim/frontPanelTb.sv

/* keyboard/keyboardScanner.sv */
`timescale 1ns/1ps

module keyboardScanner
	import panelPkg::*;
(
	input logic Clk,
	input logic reset,
	input logic kbRead,
	input logic [3:0] column,
	input logic [3:0] keyRows,
	output keyState keys
);

	// each read slot refreshes the four keys of the strobed column.
	always_ff @(posedge Clk) begin
		if (reset)
			keys <= '0;
		else if (kbRead)
			keys[4 * column +: 4] <= keyRows;
	end

endmodule

/* sim/frontPanelTb.sv */
`timescale 1ns/1ps

module frontPanelTb
	import panelPkg::*;
();

	logic Clk;
	logic reset;
	logic ms6205Ready;
	dekatronState counters;
	logic [3:0] keyRows;
	panelWord bus;
	panelStrobes strobes;
	keyState keys;

	integer seed;
	int totalChecks;
	int totalErrors;
	int testErrors [1:5];
	logic timedOut;

	// reference model of the panel.
	panelSlot mSlot;
	int mDigit;
	logic [3:0] mAddr;
	logic mGrant;
	keyState mKeys;
	panelWord mBus;

	frontPanel u_dut (
		.Clk(Clk),
		.reset(reset),
		.ms6205Ready(ms6205Ready),
		.counters(counters),
		.keyRows(keyRows),
		.bus(bus),
		.strobes(strobes),
		.keys(keys)
	);

	always #4 Clk = ~Clk;

	task automatic comparePanelWord(input string name, input panelWord got, input panelWord want,
			input int testId);
		totalChecks++;
		if (got !== want) begin
			$display("Fail at %0t: %s got %h expected %h", $time, name, got.raw, want.raw);
			totalErrors++;
			testErrors[testId]++;
		end
	endtask

	task automatic compareStrobes(input string name, input panelStrobes got,
			input panelStrobes want, input int testId);
		totalChecks++;
		if (got !== want) begin
			$display("Fail at %0t: %s got %b expected %b", $time, name, got, want);
			totalErrors++;
			testErrors[testId]++;
		end
	endtask

	task automatic compareKeys(input string name, input keyState got, input keyState want,
			input int testId);
		totalChecks++;
		if (got !== want) begin
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, want);
			totalErrors++;
			testErrors[testId]++;
		end
	endtask

	function automatic panelWord expectedCathode(input dekatronState c, input int d);
		logic [26:0] ipLoop;
		logic [27:0] apData;
		panelWord w;
		ipLoop = {c.ipCounter, c.loopCounter};
		apData = {c.apCounter, 4'h0, c.dataCounter};
		w.raw = 8'h00;
		if (d < DIGIT_COUNT - 1) begin // the last digit shows blank.
			w.pair.ipLoop = 3'(ipLoop >> (3 * d));
			w.pair.apData = 3'(apData >> (3 * d));
		end
		return w;
	endfunction

	function automatic panelWord expectedAnode(input int d);
		panelWord w;
		w.raw = (d < 8) ? 8'(1 << d) : 8'h00;
		return w;
	endfunction

	function automatic panelWord viewByte(input dekatronState c, input keyState k,
			input logic [3:0] a);
		logic [31:0] view;
		panelWord w;
		if (k[KEY_IRAM])
			view = {14'h0, c.ipCounter};
		else if (k[KEY_DRAM])
			view = {23'h0, c.dataCounter};
		else
			view = {17'h0, c.apCounter};
		w.raw = 8'(view >> (8 * (a % 4)));
		return w;
	endfunction

	task automatic resetModel();
		mSlot = slotIdle;
		mDigit = 0;
		mAddr = 4'd0;
		mGrant = 1'b0;
		mKeys = '0;
		mBus = '0;
	endtask

	// new ready every slot, new counters and rows at the start of each frame.
	task automatic driveInputs(input panelSlot target);
		logic [63:0] draw;
		ms6205Ready = ($random(seed) & 3) != 0;
		if (target == slotClear) begin
			draw = {$random(seed), $random(seed)};
			counters = draw[50:0];
			keyRows = 4'($random(seed));
		end
	endtask

	task automatic runSlot();
		panelSlot target;
		panelStrobes want;
		panelWord wantBus;
		int waited;
		int busTest;
		logic atTick;
		logic expectAny;
		target = panelSlot'(mSlot + 3'd1);
		waited = 0;
		atTick = 1'b0;
		while (!atTick && !timedOut) begin
			@(negedge Clk);
			waited++;
			expectAny = (target != slotIdle) && (target != slotMsAddr || ms6205Ready) &&
				(target != slotMsData || mGrant);
			atTick = (strobes != '0) || (!expectAny && waited == SLOT_DIVISOR);
			if (!atTick) begin
				comparePanelWord("bus between ticks", bus, mBus, 1);
				if (waited == 1)
					driveInputs(target); // the next tick is still several cycles away.
				if (waited >= 64) begin
					$display("Timeout: slot %s gave no strobe within 64 cycles", target.name());
					timedOut = 1'b1;
					totalErrors++;
				end
			end
		end
		if (!timedOut) begin
			if (waited != SLOT_DIVISOR) begin
				$display("Error at %0t: slot %s began %0d cycles after the last one", $time,
					target.name(), waited);
				totalErrors++;
				testErrors[1]++;
			end
			want = '0;
			wantBus = mBus;
			busTest = 1;
			case (target)
				slotClear: begin
					want.in12Clear = 1'b1;
					wantBus.raw = 8'h00;
				end
				slotCathode: begin
					want.in12Cathode = 1'b1;
					wantBus = expectedCathode(counters, mDigit);
					busTest = 2;
				end
				slotAnode: begin
					want.in12Anode = 1'b1;
					wantBus = expectedAnode(mDigit);
					busTest = 2;
				end
				slotKbWrite: begin
					want.kbWrite = 1'b1;
					wantBus = expectedAnode(mDigit);
					busTest = 2;
				end
				slotKbRead: want.kbRead = 1'b1;
				slotMsAddr: begin
					busTest = 4;
					if (ms6205Ready) begin
						want.msAddr = 1'b1;
						wantBus.raw = {4'h0, mAddr};
					end
				end
				slotMsData: begin
					busTest = 4;
					if (mGrant) begin
						want.msData = 1'b1;
						wantBus = viewByte(counters, mKeys, mAddr);
					end
				end
				default: wantBus.raw = 8'h00;
			endcase
			compareStrobes($sformatf("strobes in %s", target.name()), strobes, want, 1);
			comparePanelWord($sformatf("bus in %s", target.name()), bus, wantBus, busTest);
			compareKeys("keys", keys, mKeys, 3);
			mBus = wantBus;
			if (target == slotKbRead)
				mKeys[4 * mDigit +: 4] = keyRows;
			if (target == slotMsAddr)
				mGrant = ms6205Ready;
			if (target == slotMsData && mGrant)
				mAddr = mAddr + 4'd1;
			if (target == slotIdle)
				mDigit = (mDigit == DIGIT_COUNT - 1) ? 0 : mDigit + 1;
			mSlot = target;
		end
	endtask

	task automatic applyReset();
		int cycles;
		reset = 1'b1;
		for (cycles = 0; cycles < 3; cycles++) begin
			@(negedge Clk);
			compareStrobes("strobes in reset", strobes, '0, 5);
			comparePanelWord("bus in reset", bus, '0, 5);
			compareKeys("keys in reset", keys, '0, 5);
		end
		reset = 1'b0;
		resetModel();
	endtask

	task automatic reportTest(input string name, input int errors);
		$display("test %s: %s, %0d errors", name, (errors == 0) ? "ok" : "failed", errors);
	endtask

	initial begin
		int i;
		int errorsBefore;
		seed = 32'h2b8ec1d9;
		Clk = 1'b0;
		reset = 1'b1;
		ms6205Ready = 1'b0;
		counters = '0;
		keyRows = 4'h0;
		totalChecks = 0;
		totalErrors = 0;
		timedOut = 1'b0;
		for (i = 1; i <= 5; i++)
			testErrors[i] = 0;
		resetModel();
		repeat (3) @(negedge Clk);
		reset = 1'b0;
		for (i = 0; i < 40 * 8 && !timedOut; i++)
			runSlot();
		reportTest("1 slot order", testErrors[1]);
		reportTest("2 nixie words", testErrors[2]);
		reportTest("3 keyboard", testErrors[3]);
		reportTest("4 ms6205 writes", testErrors[4]);
		errorsBefore = totalErrors;
		// stop right after a keyboard read so keys hold something to clear.
		for (i = 0; i < 8 && !timedOut && mSlot != slotKbRead; i++)
			runSlot();
		if (!timedOut)
			applyReset();
		for (i = 0; i < 2 * 8 && !timedOut; i++)
			runSlot();
		reportTest("5 reset mid-run", totalErrors - errorsBefore);
		$display("checks %0d, errors %0d", totalChecks, totalErrors);
		if (totalErrors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* verilog/frontPanel.sv */
`timescale 1ns/1ps

module frontPanel
	import panelPkg::*;
(
	input logic Clk,
	input logic reset,
	input logic ms6205Ready,
	input dekatronState counters,
	input logic [3:0] keyRows,
	output panelWord bus,
	output panelStrobes strobes,
	output keyState keys
);

	logic tick;
	logic frameEnd;
	logic dataGrant;
	logic [3:0] digit;
	panelWord anodeWord;
	panelWord cathodeWord;
	panelWord addrWord;
	panelWord dataWord;

	slotTicker ticker (
		.Clk(Clk),
		.reset(reset),
		.tick(tick)
	);

	nixieScanner nixie (
		.Clk(Clk),
		.reset(reset),
		.frameEnd(frameEnd),
		.counters(counters),
		.digit(digit),
		.anodeWord(anodeWord),
		.cathodeWord(cathodeWord)
	);

	ms6205Writer ms6205 (
		.Clk(Clk),
		.reset(reset),
		.dataGrant(dataGrant),
		.counters(counters),
		.keys(keys),
		.addrWord(addrWord),
		.dataWord(dataWord)
	);

	// keyboard columns follow the nixie anode scan.
	keyboardScanner keyboard (
		.Clk(Clk),
		.reset(reset),
		.kbRead(strobes.kbRead),
		.column(digit),
		.keyRows(keyRows),
		.keys(keys)
	);

	panelSequencer sequencer (
		.Clk(Clk),
		.reset(reset),
		.tick(tick),
		.ms6205Ready(ms6205Ready),
		.anodeWord(anodeWord),
		.cathodeWord(cathodeWord),
		.addrWord(addrWord),
		.dataWord(dataWord),
		.bus(bus),
		.strobes(strobes),
		.frameEnd(frameEnd),
		.dataGrant(dataGrant)
	);

endmodule

/* verilog/panelSequencer.sv */
`timescale 1ns/1ps

module panelSequencer
	import panelPkg::*;
(
	input logic Clk,
	input logic reset,
	input logic tick,
	input logic ms6205Ready,
	input panelWord anodeWord,
	input panelWord cathodeWord,
	input panelWord addrWord,
	input panelWord dataWord,
	output panelWord bus,
	output panelStrobes strobes,
	output logic frameEnd,
	output logic dataGrant
);

	panelSlot slot;
	panelSlot nextSlot;
	logic msGranted;
	panelWord busReg;
	panelWord busNext;
	panelStrobes strobeNext;
	logic frameNext;

	assign nextSlot = panelSlot'(slot + 3'd1);

	// the tick that enters a slot drives its word and strobe in the same cycle.
	always_comb begin
		busNext = busReg;
		strobeNext = '0;
		frameNext = 1'b0;
		if (tick) begin
			case (nextSlot)
				slotClear: begin
					busNext.raw = 8'h00;
					strobeNext.in12Clear = 1'b1;
				end
				slotCathode: begin
					busNext = cathodeWord;
					strobeNext.in12Cathode = 1'b1;
				end
				slotAnode: begin
					busNext = anodeWord;
					strobeNext.in12Anode = 1'b1;
				end
				slotKbWrite: begin
					busNext = anodeWord; // the anode column doubles as keyboard strobe.
					strobeNext.kbWrite = 1'b1;
				end
				slotKbRead:
					strobeNext.kbRead = 1'b1;
				slotMsAddr: begin
					if (ms6205Ready) begin
						busNext = addrWord;
						strobeNext.msAddr = 1'b1;
					end
				end
				slotMsData: begin
					if (msGranted) begin
						busNext = dataWord;
						strobeNext.msData = 1'b1;
					end
				end
				default: begin
					busNext.raw = 8'h00;
					frameNext = 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge Clk) begin
		if (reset) begin
			slot <= slotIdle;
			msGranted <= 1'b0;
			busReg <= '0;
		end else begin
			busReg <= busNext; // held until the next tick.
			if (tick) begin
				slot <= nextSlot;
				msGranted <= (nextSlot == slotMsAddr) && ms6205Ready; // a skipped address skips its data.
			end
		end
	end

	assign bus = busNext;
	assign strobes = strobeNext;
	assign frameEnd = frameNext;
	assign dataGrant = strobeNext.msData;

endmodule

/* verilog/slotTicker.sv */
`timescale 1ns/1ps

module slotTicker
	import panelPkg::*;
(
	input logic Clk,
	input logic reset,
	output logic tick
);

	logic [SLOT_COUNT_WIDTH-1:0] count;
	logic countWrap;

	assign countWrap = (count == SLOT_COUNT_WIDTH'(SLOT_DIVISOR - 1));

	always_ff @(posedge Clk) begin
		if (reset) begin
			count <= '0;
			tick <= 1'b0;
		end else begin
			if (countWrap)
				count <= '0;
			else
				count <= count + 1'b1;
			tick <= countWrap; // one cycle wide, once per slot.
		end
	end

endmodule
